//--- build.f
+incdir+rtl
rtl/cube_pkg.sv
rtl/cube_face_table.sv
rtl/vertex_builder.sv
rtl/cube_sequencer.sv
rtl/cube_drawer.sv
testbench/tb_cube_drawer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cube drawer testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_cube_drawer -f build.f \
    -o sim_cube_drawer &&
./obj_dir/sim_cube_drawer ||
exit 1

//--- testbench/cube_input.txt
# corner line: x y z, signed Q16.16 in hex
# then 12 triangle lines: v0 x y z, v1 x y z, v2 x y z, normal x y z (2-bit, 3 is -1)
00000000 00000000 00000000
00000000 00000000 00000000 00000000 00010000 00000000 00010000 00000000 00000000 0 0 1
00010000 00010000 00000000 00010000 00000000 00000000 00000000 00010000 00000000 0 0 1
00000000 00000000 00000000 00010000 00000000 00000000 00000000 00000000 00010000 0 3 0
00010000 00000000 00010000 00000000 00000000 00010000 00010000 00000000 00000000 0 3 0
00000000 00000000 00000000 00000000 00000000 00010000 00000000 00010000 00000000 3 0 0
00000000 00010000 00010000 00000000 00010000 00000000 00000000 00000000 00010000 3 0 0
00010000 00010000 00010000 00000000 00010000 00010000 00010000 00000000 00010000 0 0 3
00000000 00000000 00010000 00010000 00000000 00010000 00000000 00010000 00010000 0 0 3
00010000 00010000 00010000 00010000 00010000 00000000 00000000 00010000 00010000 0 1 0
00000000 00010000 00000000 00000000 00010000 00010000 00010000 00010000 00000000 0 1 0
00010000 00010000 00010000 00010000 00000000 00010000 00010000 00010000 00000000 1 0 0
00010000 00000000 00000000 00010000 00010000 00000000 00010000 00000000 00010000 1 0 0
ffff8000 fffe0000 00034000
ffff8000 fffe0000 00034000 ffff8000 ffff0000 00034000 00008000 fffe0000 00034000 0 0 1
00008000 ffff0000 00034000 00008000 fffe0000 00034000 ffff8000 ffff0000 00034000 0 0 1
ffff8000 fffe0000 00034000 00008000 fffe0000 00034000 ffff8000 fffe0000 00044000 0 3 0
00008000 fffe0000 00044000 ffff8000 fffe0000 00044000 00008000 fffe0000 00034000 0 3 0
ffff8000 fffe0000 00034000 ffff8000 fffe0000 00044000 ffff8000 ffff0000 00034000 3 0 0
ffff8000 ffff0000 00044000 ffff8000 ffff0000 00034000 ffff8000 fffe0000 00044000 3 0 0
00008000 ffff0000 00044000 ffff8000 ffff0000 00044000 00008000 fffe0000 00044000 0 0 3
ffff8000 fffe0000 00044000 00008000 fffe0000 00044000 ffff8000 ffff0000 00044000 0 0 3
00008000 ffff0000 00044000 00008000 ffff0000 00034000 ffff8000 ffff0000 00044000 0 1 0
ffff8000 ffff0000 00034000 ffff8000 ffff0000 00044000 00008000 ffff0000 00034000 0 1 0
00008000 ffff0000 00044000 00008000 fffe0000 00044000 00008000 ffff0000 00034000 1 0 0
00008000 fffe0000 00034000 00008000 ffff0000 00034000 00008000 fffe0000 00044000 1 0 0
7fff8000 ffff0000 80000000
7fff8000 ffff0000 80000000 7fff8000 00000000 80000000 80008000 ffff0000 80000000 0 0 1
80008000 00000000 80000000 80008000 ffff0000 80000000 7fff8000 00000000 80000000 0 0 1
7fff8000 ffff0000 80000000 80008000 ffff0000 80000000 7fff8000 ffff0000 80010000 0 3 0
80008000 ffff0000 80010000 7fff8000 ffff0000 80010000 80008000 ffff0000 80000000 0 3 0
7fff8000 ffff0000 80000000 7fff8000 ffff0000 80010000 7fff8000 00000000 80000000 3 0 0
7fff8000 00000000 80010000 7fff8000 00000000 80000000 7fff8000 ffff0000 80010000 3 0 0
80008000 00000000 80010000 7fff8000 00000000 80010000 80008000 ffff0000 80010000 0 0 3
7fff8000 ffff0000 80010000 80008000 ffff0000 80010000 7fff8000 00000000 80010000 0 0 3
80008000 00000000 80010000 80008000 00000000 80000000 7fff8000 00000000 80010000 0 1 0
7fff8000 00000000 80000000 7fff8000 00000000 80010000 80008000 00000000 80000000 0 1 0
80008000 00000000 80010000 80008000 ffff0000 80010000 80008000 00000000 80000000 1 0 0
80008000 ffff0000 80000000 80008000 00000000 80000000 80008000 ffff0000 80010000 1 0 0

//--- testbench/tb_cube_drawer.sv
`timescale 1ns/1ps
`include "cube_consts.svh"

module tb_cube_drawer;

    localparam int num_tests = 3;
    localparam int long_stall = 40;  // longest credit return delay
    localparam int cycle_limit = num_tests * `CUBE_TRI_COUNT * (long_stall + 2) + 400;

    logic clk_in;
    logic rst_in;
    logic start;
    cube_pkg::coord_t x_corner, y_corner, z_corner;
    logic credit_return = 1'b0;
    logic tri_valid;
    cube_pkg::tri_index_t tri_index;
    cube_pkg::coord_t v0_x, v0_y, v0_z, v1_x, v1_y, v1_z, v2_x, v2_y, v2_z;
    cube_pkg::normal_t normal_x, normal_y, normal_z;
    logic busy;
    logic done;

    cube_pkg::coord_t exp_v [0:11][0:8];
    cube_pkg::normal_t exp_n [0:11][0:2];
    int held [$];  // triangles still sitting in the consumer
    integer seed = 32'hd4fb_36e6;
    int hold_cycles = 0;
    int received = 0;
    int returned = 0;
    int tri_seen = 0;
    int draws_started = 0;
    int draws_done = 0;
    int cycles = 0;

    cube_drawer u_cube_drawer (
        .clk_in(clk_in), .rst_in(rst_in), .start(start),
        .x_corner(x_corner), .y_corner(y_corner), .z_corner(z_corner),
        .credit_return(credit_return), .tri_valid(tri_valid), .tri_index(tri_index),
        .v0_x(v0_x), .v0_y(v0_y), .v0_z(v0_z), .v1_x(v1_x), .v1_y(v1_y), .v1_z(v1_z),
        .v2_x(v2_x), .v2_y(v2_y), .v2_z(v2_z),
        .normal_x(normal_x), .normal_y(normal_y), .normal_z(normal_z),
        .busy(busy), .done(done)
    );

    initial begin
        clk_in = 1'b0;
        forever begin
            #10 clk_in = ~clk_in;
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    // mostly short waits, now and then a long stall
    function automatic int next_delay();
        logic [31:0] r;
        r = $random(seed);
        if (r[1:0] == 2'b00) begin
            return long_stall;
        end
        return int'(r[4:2]);
    endfunction

    task automatic check_idle();
        assert (tri_valid == 1'b0)
            else fail_now($sformatf("error: tri_valid = %h, expected 0", tri_valid));
        assert (busy == 1'b0) else fail_now($sformatf("error: busy = %h, expected 0", busy));
        assert (done == 1'b0) else fail_now($sformatf("error: done = %h, expected 0", done));
    endtask

    task automatic check_triangle(input int t);
        cube_pkg::coord_t got_v [0:8];
        cube_pkg::normal_t got_n [0:2];
        string v_names [0:8];
        string n_names [0:2];
        got_v = '{v0_x, v0_y, v0_z, v1_x, v1_y, v1_z, v2_x, v2_y, v2_z};
        got_n = '{normal_x, normal_y, normal_z};
        v_names = '{"v0_x", "v0_y", "v0_z", "v1_x", "v1_y", "v1_z", "v2_x", "v2_y", "v2_z"};
        n_names = '{"normal_x", "normal_y", "normal_z"};
        assert (tri_index == cube_pkg::tri_index_t'(t))
            else fail_now($sformatf("error: tri_index = %h, expected %h", tri_index, t[3:0]));
        for (int i = 0; i < 9; i++) begin
            assert (got_v[i] == exp_v[t][i])
                else fail_now($sformatf("error: %s = %h, expected %h",
                    v_names[i], got_v[i], exp_v[t][i]));
        end
        for (int i = 0; i < 3; i++) begin
            assert (got_n[i] == exp_n[t][i])
                else fail_now($sformatf("error: %s = %h, expected %h",
                    n_names[i], got_n[i], exp_n[t][i]));
        end
    endtask

    // next line that is neither blank nor a comment
    task automatic read_record(input int fd, output string line, output bit found);
        int n;
        found = 1'b0;
        line = "";
        while (!found && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                found = 1'b1;
            end
        end
    endtask

    task automatic draw_cube(input cube_pkg::coord_t cx, cy, cz);
        int k;
        k = 0;
        @(negedge clk_in);
        x_corner = cx;
        y_corner = cy;
        z_corner = cz;
        start = 1'b1;
        draws_started++;
        do begin
            @(negedge clk_in);
            k++;
            start = (k == 3);  // second start mid draw, must be ignored
            if (k == 1) begin
                x_corner = ~cx;  // corner was captured on accept
                y_corner = ~cy;
                z_corner = ~cz;
            end
            if (done) begin
                assert (!busy) else fail_now($sformatf("error: busy = %h, expected 0", busy));
            end else begin
                assert (busy) else fail_now($sformatf("error: busy = %h, expected 1", busy));
            end
        end while (!done);
        repeat (8) begin
            @(negedge clk_in);
            check_idle();
        end
    endtask

    // consumer model and output monitor
    always @(negedge clk_in) begin
        if (credit_return) begin
            returned++;  // taken at the last rising edge
        end
        if (tri_valid) begin
            assert (draws_done < draws_started)
                else fail_now("a triangle arrived while no draw was in progress");
            check_triangle(tri_seen);
            held.push_back(tri_seen);
            received++;
            assert (done == (tri_seen == `CUBE_TRI_COUNT - 1))
                else fail_now($sformatf("error: done = %h, expected %h",
                    done, tri_seen == `CUBE_TRI_COUNT - 1));
            if (done) begin
                draws_done++;
                tri_seen = 0;
            end else begin
                tri_seen++;
            end
        end else begin
            assert (!done) else fail_now($sformatf("error: done = %h, expected 0", done));
        end
        assert (received - returned <= `CUBE_TRI_CREDITS)
            else fail_now("the DUT sent more triangles than the consumer has slots for");
        if (held.size() > 0 && hold_cycles == 0) begin
            void'(held.pop_front());
            credit_return = 1'b1;
            hold_cycles = next_delay();
        end else begin
            credit_return = 1'b0;
            if (hold_cycles > 0) begin
                hold_cycles--;
            end
        end
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles > cycle_limit) begin
            fail_now($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        int fd;
        int n;
        int tests_run;
        bit found;
        string line;
        cube_pkg::coord_t cx, cy, cz;
        start = 1'b0;
        rst_in = 1'b1;
        x_corner = '0;
        y_corner = '0;
        z_corner = '0;
        tests_run = 0;
        repeat (5) begin
            @(negedge clk_in);
            check_idle();
        end
        rst_in = 1'b0;
        @(negedge clk_in);
        check_idle();

        fd = $fopen("testbench/cube_input.txt", "r");
        if (fd == 0) begin
            fail_now("could not open testbench/cube_input.txt");
        end
        read_record(fd, line, found);
        while (found) begin
            n = $sscanf(line, "%h %h %h", cx, cy, cz);
            assert (n == 3) else fail_now("a corner line in the data file is malformed");
            for (int t = 0; t < `CUBE_TRI_COUNT; t++) begin
                read_record(fd, line, found);
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                    exp_v[t][0], exp_v[t][1], exp_v[t][2], exp_v[t][3], exp_v[t][4],
                    exp_v[t][5], exp_v[t][6], exp_v[t][7], exp_v[t][8],
                    exp_n[t][0], exp_n[t][1], exp_n[t][2]);
                assert (found && n == 12)
                    else fail_now("a triangle line in the data file is missing or malformed");
            end
            draw_cube(cx, cy, cz);
            tests_run++;
            read_record(fd, line, found);
        end
        $fclose(fd);
        assert (tests_run == num_tests)
            else fail_now($sformatf("data file held %0d corners, not %0d", tests_run, num_tests));
        $display("Test passed");
        $finish;
    end

endmodule

//--- rtl/cube_drawer.sv
`timescale 1ns/1ps

module cube_drawer (
    input logic clk_in,
    input logic rst_in,
    input logic start,
    input cube_pkg::coord_t x_corner,
    input cube_pkg::coord_t y_corner,
    input cube_pkg::coord_t z_corner,
    input logic credit_return,
    output logic tri_valid,
    output cube_pkg::tri_index_t tri_index,
    output cube_pkg::coord_t v0_x,
    output cube_pkg::coord_t v0_y,
    output cube_pkg::coord_t v0_z,
    output cube_pkg::coord_t v1_x,
    output cube_pkg::coord_t v1_y,
    output cube_pkg::coord_t v1_z,
    output cube_pkg::coord_t v2_x,
    output cube_pkg::coord_t v2_y,
    output cube_pkg::coord_t v2_z,
    output cube_pkg::normal_t normal_x,
    output cube_pkg::normal_t normal_y,
    output cube_pkg::normal_t normal_z,
    output logic busy,
    output logic done
);

    logic load;
    logic emit;
    cube_pkg::tri_index_t seq_index;
    cube_pkg::vertex_offsets_t offsets;
    cube_pkg::normal_t tbl_normal_x, tbl_normal_y, tbl_normal_z;

    cube_sequencer u_sequencer (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .start(start),
        .credit_return(credit_return),
        .load(load),
        .emit(emit),
        .index(seq_index),
        .busy(busy),
        .done(done)
    );

    cube_face_table u_table (
        .index(seq_index),
        .offsets(offsets),
        .normal_x(tbl_normal_x),
        .normal_y(tbl_normal_y),
        .normal_z(tbl_normal_z)
    );

    // output stage, index travels with the vertex data
    vertex_builder u_builder (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .load(load),
        .emit(emit),
        .x_corner(x_corner),
        .y_corner(y_corner),
        .z_corner(z_corner),
        .index(seq_index),
        .offsets(offsets),
        .normal_x(tbl_normal_x),
        .normal_y(tbl_normal_y),
        .normal_z(tbl_normal_z),
        .tri_valid(tri_valid),
        .tri_index(tri_index),
        .v0_x(v0_x),
        .v0_y(v0_y),
        .v0_z(v0_z),
        .v1_x(v1_x),
        .v1_y(v1_y),
        .v1_z(v1_z),
        .v2_x(v2_x),
        .v2_y(v2_y),
        .v2_z(v2_z),
        .normal_x_out(normal_x),
        .normal_y_out(normal_y),
        .normal_z_out(normal_z)
    );

endmodule

//--- rtl/cube_sequencer.sv
`timescale 1ns/1ps
`include "cube_consts.svh"

module cube_sequencer (
    input logic clk_in,
    input logic rst_in,
    input logic start,
    input logic credit_return,
    output logic load,
    output logic emit,
    output cube_pkg::tri_index_t index,
    output logic busy,
    output logic done
);

    cube_pkg::draw_state_t state;
    cube_pkg::credit_t credits;
    logic last_tri;

    // start only seen while not busy, DONE counts as idle
    assign load = (state != cube_pkg::EMIT) && start;
    assign emit = (state == cube_pkg::EMIT) && (credits != '0);
    assign last_tri = (index == cube_pkg::tri_index_t'(`CUBE_TRI_COUNT - 1));

    assign busy = (state == cube_pkg::EMIT);
    assign done = (state == cube_pkg::DONE);  // one cycle, same as last tri_valid

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= cube_pkg::IDLE;
            index <= '0;
        end else begin
            case (state)
                cube_pkg::IDLE: begin
                    index <= '0;
                    if (start) begin
                        state <= cube_pkg::EMIT;
                    end
                end
                cube_pkg::EMIT: begin
                    // no credit means hold here with index unchanged
                    if (emit) begin
                        if (last_tri) begin
                            state <= cube_pkg::DONE;
                        end else begin
                            index <= index + 1'b1;
                        end
                    end
                end
                cube_pkg::DONE: begin
                    if (start) begin
                        state <= cube_pkg::EMIT;  // back to back draw
                        index <= '0;
                    end else begin
                        state <= cube_pkg::IDLE;
                    end
                end
                default: begin
                    state <= cube_pkg::IDLE;
                end
            endcase
        end
    end

    // one credit per slot at the consumer
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            credits <= cube_pkg::credit_t'(`CUBE_TRI_CREDITS);
        end else if (emit && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!emit && credit_return) begin
            credits <= credits + 1'b1;
        end
    end

endmodule

//--- rtl/vertex_builder.sv
`timescale 1ns/1ps
`include "cube_consts.svh"

module vertex_builder (
    input logic clk_in,
    input logic rst_in,
    input logic load,
    input logic emit,
    input cube_pkg::coord_t x_corner,
    input cube_pkg::coord_t y_corner,
    input cube_pkg::coord_t z_corner,
    input cube_pkg::tri_index_t index,
    input cube_pkg::vertex_offsets_t offsets,
    input cube_pkg::normal_t normal_x,
    input cube_pkg::normal_t normal_y,
    input cube_pkg::normal_t normal_z,
    output logic tri_valid,
    output cube_pkg::tri_index_t tri_index,
    output cube_pkg::coord_t v0_x,
    output cube_pkg::coord_t v0_y,
    output cube_pkg::coord_t v0_z,
    output cube_pkg::coord_t v1_x,
    output cube_pkg::coord_t v1_y,
    output cube_pkg::coord_t v1_z,
    output cube_pkg::coord_t v2_x,
    output cube_pkg::coord_t v2_y,
    output cube_pkg::coord_t v2_z,
    output cube_pkg::normal_t normal_x_out,
    output cube_pkg::normal_t normal_y_out,
    output cube_pkg::normal_t normal_z_out
);

    cube_pkg::coord_t x_base, y_base, z_base;  // corner held for the whole draw

    // wraps on overflow
    function automatic cube_pkg::coord_t place(input cube_pkg::coord_t base, input logic sel);
        place = sel ? base + cube_pkg::coord_t'(`CUBE_EDGE) : base;
    endfunction

    always_ff @(posedge clk_in) begin
        if (load) begin
            x_base <= x_corner;
            y_base <= y_corner;
            z_base <= z_corner;
        end
    end

    always_ff @(posedge clk_in) begin
        if (emit) begin
            tri_index <= index;
            v0_x <= place(x_base, offsets[8]);
            v0_y <= place(y_base, offsets[7]);
            v0_z <= place(z_base, offsets[6]);
            v1_x <= place(x_base, offsets[5]);
            v1_y <= place(y_base, offsets[4]);
            v1_z <= place(z_base, offsets[3]);
            v2_x <= place(x_base, offsets[2]);
            v2_y <= place(y_base, offsets[1]);
            v2_z <= place(z_base, offsets[0]);
            normal_x_out <= normal_x;
            normal_y_out <= normal_y;
            normal_z_out <= normal_z;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tri_valid <= 1'b0;
        end else begin
            tri_valid <= emit;  // one cycle per triangle
        end
    end

endmodule

//--- rtl/cube_face_table.sv
`timescale 1ns/1ps

module cube_face_table (
    input cube_pkg::tri_index_t index,
    output cube_pkg::vertex_offsets_t offsets,
    output cube_pkg::normal_t normal_x,
    output cube_pkg::normal_t normal_y,
    output cube_pkg::normal_t normal_z
);

    localparam cube_pkg::normal_t POS = 2'sb01;
    localparam cube_pkg::normal_t NEG = 2'sb11;

    logic [2:0] face;

    assign face = index[3:1];  // two triangles per face

    // corner selection per vertex in v0_v1_v2 order
    always_comb begin
        case (index)
            4'd0: offsets = 9'b000_010_100;   // z low
            4'd1: offsets = 9'b110_100_010;
            4'd2: offsets = 9'b000_100_001;   // y low
            4'd3: offsets = 9'b101_001_100;
            4'd4: offsets = 9'b000_001_010;   // x low
            4'd5: offsets = 9'b011_010_001;
            4'd6: offsets = 9'b111_011_101;   // z high
            4'd7: offsets = 9'b001_101_011;
            4'd8: offsets = 9'b111_110_011;   // y high
            4'd9: offsets = 9'b010_011_110;
            4'd10: offsets = 9'b111_101_110;  // x high
            4'd11: offsets = 9'b100_110_101;
            default: offsets = '0;
        endcase
    end

    // both z faces carry inward normals
    always_comb begin
        normal_x = '0;
        normal_y = '0;
        normal_z = '0;
        case (face)
            3'd0: begin
                normal_z = POS;
            end
            3'd1: begin
                normal_y = NEG;
            end
            3'd2: begin
                normal_x = NEG;
            end
            3'd3: begin
                normal_z = NEG;
            end
            3'd4: begin
                normal_y = POS;
            end
            3'd5: begin
                normal_x = POS;
            end
            default: begin
                normal_x = '0;
            end
        endcase
    end

endmodule

//--- rtl/cube_pkg.sv
`include "cube_consts.svh"

package cube_pkg;

    typedef logic signed [`CUBE_COORD_WIDTH-1:0] coord_t;

    typedef logic signed [`CUBE_NORMAL_WIDTH-1:0] normal_t;

    typedef logic [`CUBE_INDEX_WIDTH-1:0] tri_index_t;

    // msb first: v0 x,y,z then v1 x,y,z then v2 x,y,z
    // set bit means corner plus edge on that axis
    typedef logic [8:0] vertex_offsets_t;

    typedef logic [`CUBE_CREDIT_WIDTH-1:0] credit_t;

    typedef enum logic [1:0] {
        IDLE,
        EMIT,
        DONE
    } draw_state_t;

endpackage

//--- rtl/cube_consts.svh
`ifndef CUBE_CONSTS_SVH
`define CUBE_CONSTS_SVH

// signed Q16.16 coordinate
`define CUBE_COORD_WIDTH 32

// normal component, one of -1, 0, +1
`define CUBE_NORMAL_WIDTH 2

`define CUBE_TRI_COUNT 12
`define CUBE_INDEX_WIDTH 4

// edge length, 1.0 in Q16.16
`define CUBE_EDGE 32'h0001_0000

`define CUBE_TRI_CREDITS 4  // triangles the consumer can hold
`define CUBE_CREDIT_WIDTH 3

`endif
